// File: dv/ltssm_recovery_properties.sv
//------------------------------
// concurrent checks on the ordered-set stream
// and on the result outputs of the recovery block
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module ltssm_recovery_properties (
  input logic        clk_i,
  input logic        rst_i,
  input logic [31:0] tdata_i,
  input logic        tvalid_i,
  input logic        tlast_i,
  input logic        tready_i,
  input logic        success_i,
  input logic        error_i,
  input logic        goto_cfg_i,
  input logic        goto_detect_i
);

  // a stalled word stays on the bus unchanged until accepted
  a_stream_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    tvalid_i && !tready_i |=> tvalid_i && $stable(tdata_i) && $stable(tlast_i))
    else $error("stream word changed or dropped before it was accepted");

  a_last_valid: assert property (@(posedge clk_i) disable iff (rst_i) tlast_i |-> tvalid_i)
    else $error("tlast high while tvalid is low");

  a_result_excl: assert property (@(posedge clk_i) disable iff (rst_i) !(success_i && error_i))
    else $error("success and error high together");

  // at most one exit direction
  a_goto_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0({goto_cfg_i, goto_detect_i}))
    else $error("goto_cfg and goto_detect high together");

endmodule

`default_nettype wire

// File: dv/recovery_golden.txt
// one scenario per line, 8 hex digits, most significant first:
// lane mask, good TS1, bad TS1, bad kind (0 link, 1 ec), TS2 count, req_equal, gen3, outcome
// outcome 1 success, 2 goto_cfg, 3 goto_detect
F8008111 // all lanes, gen3 request
58008001 // lanes 0 and 2
39008001 // extra TS1 before Cfg
18008111 // lane 0 only
F0800002 // wrong link number
65310002 // nonzero ec breaks the run
F4610012
F0000003 // nothing received
10000013
F8008013 // TS2 without req_equal
C8008103 // TS2 with unexpected req_equal

// File: dv/tb_ltssm_recovery.sv
//------------------------------
// testbench for the recovery block
// golden-file scenarios, lane stimulus, stream monitor
//------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "ltssm_rcvr_macros.svh"

module tb_ltssm_recovery;

  import ltssm_rcvr_pkg::*;

  localparam int N            = `LTSSM_NUM_LANES;
  localparam int NUM_SCEN     = 11;
  localparam int RESULT_LIMIT = 3000;
  localparam int FRAME_LIMIT  = 1000;

  logic                clk_i;
  logic                rst_i;
  logic                en_i;
  logic [7:0]          link_num_i;
  logic                max_rate_gen3_i;
  logic [N-1:0]        lane_active_i;
  logic [N-1:0]        ts1_valid_i;
  logic [N-1:0]        ts2_valid_i;
  logic [N-1:0][7:0]   rx_link_num_i;
  logic [N-1:0][7:0]   rx_lane_num_i;
  ts_symbol6_u [N-1:0] symbol6_i;
  logic [31:0]         tdata_o;
  logic                tvalid_o;
  logic                tlast_o;
  logic                tready_i;
  logic                success_o;
  logic                error_o;
  logic                goto_cfg_o;
  logic                goto_detect_o;

  logic [31:0] golden [NUM_SCEN];
  int          errors;
  int          checks;
  // stream monitor state
  logic [1:0]  mon_idx;
  logic [7:0]  frame_id;
  logic        hold_pending;
  logic [31:0] held_data;
  logic        held_last;
  logic        ts2_seen;
  logic        ts2_allowed;

  ltssm_recovery #(.TIMEOUT_CYCLES(400)) dut (.*);

  bind ltssm_recovery ltssm_recovery_properties u_props (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .tdata_i       (tdata_o),
    .tvalid_i      (tvalid_o),
    .tlast_i       (tlast_o),
    .tready_i      (tready_i),
    .success_i     (success_o),
    .error_i       (error_o),
    .goto_cfg_i    (goto_cfg_o),
    .goto_detect_i (goto_detect_o)
  );

  always #20 clk_i = ~clk_i;

  // sink accepts about 70 % of cycles
  always @(posedge clk_i) begin
    #2;
    tready_i = ($urandom_range(99, 0) < 70);
  end

  task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, act, exp, $time);
    end
  endtask

  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  task automatic check_idle();
    check_val("tvalid_o", tvalid_o, 0);
    check_val("tlast_o", tlast_o, 0);
    check_val("success_o", success_o, 0);
    check_val("error_o", error_o, 0);
    check_val("goto_cfg_o", goto_cfg_o, 0);
    check_val("goto_detect_o", goto_detect_o, 0);
  endtask

  //------------------------------
  // stream monitor
  //------------------------------
  task automatic check_word();
    logic [7:0] sym6;
    case (mon_idx)
      2'd0: begin
        check_val("tdata_o word 0", tdata_o, {`LTSSM_NFTS, 8'h00, link_num_i, `LTSSM_COM});
      end
      2'd1: begin
        // once Cfg is reached every frame is a TS2
        if (ts2_seen || (ts2_allowed && tdata_o[31:24] == `LTSSM_TS2_ID)) begin
          frame_id = `LTSSM_TS2_ID;
          sym6 = {max_rate_gen3_i, 7'd0};
          ts2_seen = 1'b1;
        end else begin
          frame_id = `LTSSM_TS1_ID;
          sym6 = 8'h00;
        end
        check_val("tdata_o word 1", tdata_o, {frame_id, sym6, 8'h00, `LTSSM_RATE_SYM});
      end
      default: begin
        check_val("tdata_o word 2/3", tdata_o, {4{frame_id}});
      end
    endcase
  endtask

  always @(negedge clk_i) begin
    if (rst_i) begin
      mon_idx      = 2'd0;
      hold_pending = 1'b0;
    end else begin
      if (hold_pending) begin
        check_val("tvalid_o held", tvalid_o, 1);
        check_val("tdata_o held", tdata_o, held_data);
        check_val("tlast_o held", tlast_o, held_last);
      end
      check_val("tlast_o", tlast_o, tvalid_o && (mon_idx == 2'd3));
      if (tvalid_o) begin
        check_word();
        held_data = tdata_o;
        held_last = tlast_o;
        if (tready_i) begin
          mon_idx = mon_idx + 2'd1;
        end
      end
      hold_pending = tvalid_o && !tready_i;
    end
  end

  //------------------------------
  // lane stimulus and waits
  //------------------------------
  task automatic send_sets(input logic [N-1:0] mask, input int count, input bit is_ts2,
                           input bit bad, input bit bad_ec, input logic req_eq);
    ts_symbol6_u sym;
    for (int k = 0; k < count; k++) begin
      repeat ($urandom_range(3, 0)) step();
      sym = '0;
      if (is_ts2) begin
        sym.ts2.req_equal = req_eq;
      end else if (bad && bad_ec) begin
        sym.ts1.ec = 2'b01;
      end
      for (int l = 0; l < N; l++) begin
        rx_link_num_i[l] = (bad && !bad_ec) ? ~link_num_i : link_num_i;
        rx_lane_num_i[l] = 8'(l);
        symbol6_i[l]     = sym;
      end
      ts1_valid_i = is_ts2 ? '0 : mask;
      ts2_valid_i = is_ts2 ? mask : '0;
      step();
      ts1_valid_i = '0;
      ts2_valid_i = '0;
    end
  endtask

  task automatic wait_for_ts2();
    int n = 0;
    while (!ts2_seen && n < FRAME_LIMIT) begin
      step();
      n++;
    end
    if (!ts2_seen) begin
      errors++;
      $display("timeout: no TS2 frame on the stream within %0d cycles", FRAME_LIMIT);
    end
  endtask

  task automatic wait_for_result();
    int n = 0;
    while (!(success_o || error_o) && n < RESULT_LIMIT) begin
      step();
      n++;
    end
    if (!(success_o || error_o)) begin
      errors++;
      $display("timeout: neither success nor error rose within %0d cycles", RESULT_LIMIT);
    end
  endtask

  // record nibbles from the top give mask, good, bad, bad kind, ts2, req_equal, gen3, outcome
  task automatic run_scenario(input logic [31:0] rec);
    logic [N-1:0] mask;
    logic [3:0]   outcome;
    int           lock_sets;
    mask            = rec[31:28];
    outcome         = rec[3:0];
    max_rate_gen3_i = rec[4];
    link_num_i      = 8'($urandom_range(254, 1));
    lane_active_i   = mask;
    ts2_seen        = 1'b0;
    ts2_allowed     = 1'b0;
    check_idle();
    en_i = 1'b1;
    step();
    check_val("tvalid_o after enable", tvalid_o, 1);
    // TS2 frames may only follow a full run of good TS1
    lock_sets = (rec[27:24] > `LTSSM_LOCK_CNT) ? `LTSSM_LOCK_CNT : rec[27:24];
    send_sets(mask, lock_sets, 0, 0, 0, 0);
    ts2_allowed = (lock_sets == `LTSSM_LOCK_CNT);
    send_sets(mask, rec[27:24] - lock_sets, 0, 0, 0, 0);
    send_sets(mask, rec[23:20], 0, 1, rec[16], 0);
    if (rec[15:12] != 4'd0) begin
      wait_for_ts2();
      send_sets(mask, rec[15:12], 1, 0, 0, rec[8]);
    end
    wait_for_result();
    check_val("success_o", success_o, outcome == 4'd1);
    check_val("error_o", error_o, outcome != 4'd1);
    check_val("goto_cfg_o", goto_cfg_o, outcome == 4'd2);
    check_val("goto_detect_o", goto_detect_o, outcome == 4'd3);
    en_i = 1'b0;
    step();
    check_idle();
  endtask

  initial begin
    errors          = 0;
    checks          = 0;
    void'($urandom(74));
    clk_i           = 1'b0;
    rst_i           = 1'b1;
    en_i            = 1'b0;
    link_num_i      = 8'h00;
    max_rate_gen3_i = 1'b0;
    lane_active_i   = '0;
    ts1_valid_i     = '0;
    ts2_valid_i     = '0;
    rx_link_num_i   = '0;
    rx_lane_num_i   = '0;
    symbol6_i       = '0;
    tready_i        = 1'b0;
    ts2_seen        = 1'b0;
    ts2_allowed     = 1'b0;
    $readmemh("dv/recovery_golden.txt", golden);
    repeat (16) begin
      step();
      check_idle();
    end
    rst_i = 1'b0;
    repeat (4) begin
      step();
      check_idle();
    end
    if ($isunknown(golden[0]) || $isunknown(golden[NUM_SCEN-1])) begin
      errors++;
      $display("golden scenario file is missing or incomplete");
    end else begin
      for (int s = 0; s < NUM_SCEN; s++) begin
        run_scenario(golden[s]);
      end
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+verilog
verilog/ltssm_rcvr_pkg.sv
verilog/ltssm_rcvr_lane_if.sv
verilog/ltssm_rcvr_lane_cnt.sv
verilog/ltssm_rcvr_os_tx.sv
verilog/ltssm_rcvr_fsm.sv
verilog/ltssm_recovery.sv
dv/ltssm_recovery_properties.sv
dv/tb_ltssm_recovery.sv

// File: verilog/ltssm_rcvr_fsm.sv
//------------------------------
// recovery state machine
// Lock and Cfg sequencing, timeout timer, results
//------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "ltssm_rcvr_macros.svh"

module ltssm_rcvr_fsm #(
  parameter int TIMEOUT_CYCLES = `LTSSM_TIMEOUT_CYCLES
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        en_i,
  input  logic [`LTSSM_NUM_LANES-1:0] lane_active_i,
  ltssm_rcvr_lane_if.fsm              lane_if,
  output logic                        send_o,
  output ltssm_rcvr_pkg::os_kind_e    kind_o,
  input  logic                        frame_end_i,
  output logic                        success_o,
  output logic                        error_o,
  output logic                        goto_cfg_o,
  output logic                        goto_detect_o
);

  import ltssm_rcvr_pkg::*;

  localparam logic [31:0] TIMEOUT = 32'(TIMEOUT_CYCLES);

  rcvr_state_e state_q;
  rcvr_state_e state_d;
  logic [31:0] timer_q;
  logic        timed_out;
  logic        clear;
  logic        lock_ok;
  logic        cfg_ok;
  logic        seen_any;
  logic        fin;
  logic        fin_ok;
  logic        fin_cfg;

  // inactive lanes never hold up the sequence
  assign lock_ok   = &(lane_if.lock_met | ~lane_active_i);
  assign cfg_ok    = &(lane_if.cfg_met | ~lane_active_i);
  assign seen_any  = |(lane_if.any_seen & lane_active_i);
  assign timed_out = (timer_q >= TIMEOUT);

  assign lane_if.clear     = clear;
  assign lane_if.cfg_phase = (state_q == RCVR_CFG);
  assign send_o = (state_q == RCVR_LOCK) || (state_q == RCVR_CFG);
  assign kind_o = (state_q == RCVR_CFG) ? OS_TS2 : OS_TS1;

  //------------------------------
  // next state
  //------------------------------
  always_comb begin
    state_d = state_q;
    clear   = 1'b0;
    fin     = 1'b0;
    fin_ok  = 1'b0;
    fin_cfg = 1'b0;
    case (state_q)
      RCVR_IDLE: begin
        if (en_i) begin
          state_d = RCVR_LOCK;
          clear   = 1'b1;
        end
      end
      RCVR_LOCK: begin
        if (frame_end_i) begin
          if (lock_ok) begin
            state_d = RCVR_CFG;
            clear   = 1'b1;
          end else if (timed_out) begin
            state_d = RCVR_DONE;
            fin     = 1'b1;
            fin_cfg = seen_any;
          end
        end
      end
      RCVR_CFG: begin
        if (frame_end_i) begin
          if (cfg_ok) begin
            state_d = RCVR_DONE;
            fin     = 1'b1;
            fin_ok  = 1'b1;
          end else if (timed_out) begin
            state_d = RCVR_DONE;
            fin     = 1'b1;
          end
        end
      end
      default: begin
        // results held until enable drops
        if (!en_i) begin
          state_d = RCVR_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q       <= RCVR_IDLE;
      timer_q       <= '0;
      success_o     <= 1'b0;
      error_o       <= 1'b0;
      goto_cfg_o    <= 1'b0;
      goto_detect_o <= 1'b0;
    end else begin
      state_q <= state_d;
      // bounded timer, restarted with each counter clear
      if (clear) begin
        timer_q <= '0;
      end else if (send_o && !timed_out) begin
        timer_q <= timer_q + 32'd1;
      end
      if ((state_q == RCVR_DONE) && !en_i) begin
        success_o     <= 1'b0;
        error_o       <= 1'b0;
        goto_cfg_o    <= 1'b0;
        goto_detect_o <= 1'b0;
      end else if (fin) begin
        success_o     <= fin_ok;
        error_o       <= !fin_ok;
        goto_cfg_o    <= !fin_ok && fin_cfg;
        goto_detect_o <= !fin_ok && !fin_cfg;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/ltssm_rcvr_lane_cnt.sv
//------------------------------
// per-lane receive counters
// consecutive matching TS1/TS2 for Lock, TS2 for Cfg
//------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "ltssm_rcvr_macros.svh"

module ltssm_rcvr_lane_cnt (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  ltssm_rcvr_lane_if.lane                                   lane_if,
  input  logic [`LTSSM_NUM_LANES-1:0]                       ts1_valid_i,
  input  logic [`LTSSM_NUM_LANES-1:0]                       ts2_valid_i,
  input  logic [`LTSSM_NUM_LANES-1:0][7:0]                  rx_link_num_i,
  input  logic [`LTSSM_NUM_LANES-1:0][7:0]                  rx_lane_num_i,
  input  ltssm_rcvr_pkg::ts_symbol6_u [`LTSSM_NUM_LANES-1:0] symbol6_i,
  input  logic [7:0]                                        link_num_i,
  input  logic                                              max_rate_gen3_i
);

  localparam int MAX_CNT = (`LTSSM_LOCK_CNT > `LTSSM_CFG_CNT) ? `LTSSM_LOCK_CNT : `LTSSM_CFG_CNT;
  localparam int CNT_W = $clog2(MAX_CNT + 1);
  localparam logic [CNT_W-1:0] LOCK_THR = CNT_W'(`LTSSM_LOCK_CNT);
  localparam logic [CNT_W-1:0] CFG_THR = CNT_W'(`LTSSM_CFG_CNT);

  for (genvar i = 0; i < `LTSSM_NUM_LANES; i++) begin : gen_lane
    logic [CNT_W-1:0] cnt_q;
    logic             seen_q;
    logic             match;
    logic             strobe;
    logic             good;
    logic [CNT_W-1:0] sat;

    // set must carry our link number and this lane's index
    assign match = (rx_link_num_i[i] == link_num_i) && (rx_lane_num_i[i] == 8'(i));
    assign strobe = ts1_valid_i[i] | ts2_valid_i[i];

    // Cfg accepts only TS2 with the expected equalization request
    assign good = match && (lane_if.cfg_phase ?
                  (ts2_valid_i[i] && (symbol6_i[i].ts2.req_equal == max_rate_gen3_i)) :
                  (ts2_valid_i[i] || (ts1_valid_i[i] && (symbol6_i[i].ts1.ec == 2'b00))));
    assign sat = lane_if.cfg_phase ? CFG_THR : LOCK_THR;

    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        cnt_q  <= '0;
        seen_q <= 1'b0;
      end else if (lane_if.clear) begin
        cnt_q  <= '0;
        seen_q <= 1'b0;
      end else if (strobe) begin
        seen_q <= 1'b1;
        // a break in the run starts the count over
        if (!good) begin
          cnt_q <= '0;
        end else if (cnt_q < sat) begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end

    assign lane_if.lock_met[i] = (cnt_q >= LOCK_THR);
    assign lane_if.cfg_met[i]  = (cnt_q >= CFG_THR);
    assign lane_if.any_seen[i] = seen_q;
  end

endmodule

`default_nettype wire

// File: verilog/ltssm_rcvr_lane_if.sv
//------------------------------
// lane counter interface
//------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "ltssm_rcvr_macros.svh"

interface ltssm_rcvr_lane_if;

  // control from the state machine
  logic                        clear;
  logic                        cfg_phase;
  // per-lane status from the counters
  logic [`LTSSM_NUM_LANES-1:0] lock_met;
  logic [`LTSSM_NUM_LANES-1:0] cfg_met;
  logic [`LTSSM_NUM_LANES-1:0] any_seen;

  modport fsm (output clear, output cfg_phase, input lock_met, input cfg_met, input any_seen);
  modport lane (input clear, input cfg_phase, output lock_met, output cfg_met, output any_seen);

endinterface

`default_nettype wire

// File: verilog/ltssm_rcvr_macros.svh
//------------------------------
// lane count, timeout and frame size defaults
// ordered-set symbol values and count thresholds
//------------------------------
`ifndef LTSSM_RCVR_MACROS_SVH
`define LTSSM_RCVR_MACROS_SVH

`define LTSSM_NUM_LANES      4
// 24 ms at 100 MHz
`define LTSSM_TIMEOUT_CYCLES 2400000
`define LTSSM_OS_WORDS       4
`define LTSSM_LOCK_CNT       8
`define LTSSM_CFG_CNT        8

// training set symbols
`define LTSSM_COM            8'hBC
`define LTSSM_TS1_ID         8'h4A
`define LTSSM_TS2_ID         8'h45
`define LTSSM_NFTS           8'h20
`define LTSSM_RATE_SYM       8'h02

`endif

// File: verilog/ltssm_rcvr_os_tx.sv
//------------------------------
// TS1/TS2 ordered-set transmitter
// four-word frames, valid/ready with last
//------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "ltssm_rcvr_macros.svh"

module ltssm_rcvr_os_tx (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     send_i,
  input  ltssm_rcvr_pkg::os_kind_e kind_i,
  input  logic [7:0]               link_num_i,
  input  logic                     max_rate_gen3_i,
  output logic                     frame_end_o,
  output logic [31:0]              tdata_o,
  output logic                     tvalid_o,
  output logic                     tlast_o,
  input  logic                     tready_i
);

  import ltssm_rcvr_pkg::*;

  localparam logic [1:0] LAST_WORD = 2'(`LTSSM_OS_WORDS - 1);

  logic [1:0]  word_idx_q;
  os_kind_e    kind_q;
  logic        xfer;
  ts_symbol6_u sym6;
  logic [7:0]  os_id;

  // a started frame always runs to its last word
  assign tvalid_o    = send_i | (word_idx_q != 2'd0);
  assign tlast_o     = (word_idx_q == LAST_WORD);
  assign xfer        = tvalid_o & tready_i;
  assign frame_end_o = xfer & tlast_o;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      word_idx_q <= 2'd0;
      kind_q     <= OS_TS1;
    end else if (xfer) begin
      word_idx_q <= tlast_o ? 2'd0 : word_idx_q + 2'd1;
      // kind is fixed for the frame once word 0 goes out
      if (word_idx_q == 2'd0) begin
        kind_q <= kind_i;
      end
    end
  end

  //------------------------------
  // word contents, byte 0 in bits 7:0
  //------------------------------
  always_comb begin
    sym6 = '0;
    if (kind_q == OS_TS2) begin
      sym6.ts2.req_equal = max_rate_gen3_i;
    end
    os_id = (kind_q == OS_TS2) ? `LTSSM_TS2_ID : `LTSSM_TS1_ID;
    case (word_idx_q)
      2'd0: begin
        // lane number field is 0 in the lane 0 template
        tdata_o = {`LTSSM_NFTS, 8'h00, link_num_i, `LTSSM_COM};
      end
      2'd1: begin
        tdata_o = {os_id, sym6, 8'h00, `LTSSM_RATE_SYM};
      end
      default: begin
        tdata_o = {4{os_id}};
      end
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/ltssm_rcvr_pkg.sv
//------------------------------
// shared types for the recovery block
// symbol 6 union, state enum, ordered-set kind
//------------------------------
`default_nettype none

package ltssm_rcvr_pkg;

  // symbol 6 as seen in a TS1
  typedef struct packed {
    logic [5:0] rsvd;
    logic [1:0] ec;
  } ts1_symbol6_t;

  // symbol 6 as seen in a TS2, req_equal in bit 7
  typedef struct packed {
    logic       req_equal;
    logic [6:0] rsvd;
  } ts2_symbol6_t;

  typedef union packed {
    ts1_symbol6_t ts1;
    ts2_symbol6_t ts2;
  } ts_symbol6_u;

  typedef enum logic [1:0] {
    RCVR_IDLE,
    RCVR_LOCK,
    RCVR_CFG,
    RCVR_DONE
  } rcvr_state_e;

  typedef enum logic {
    OS_TS1,
    OS_TS2
  } os_kind_e;

endpackage

`default_nettype wire

// File: verilog/ltssm_recovery.sv
//------------------------------
// recovery top level
// lane counters, state machine, ordered-set transmitter
//------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "ltssm_rcvr_macros.svh"

module ltssm_recovery #(
  parameter int TIMEOUT_CYCLES = `LTSSM_TIMEOUT_CYCLES
) (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  input  logic                                              en_i,
  input  logic [7:0]                                        link_num_i,
  input  logic                                              max_rate_gen3_i,
  input  logic [`LTSSM_NUM_LANES-1:0]                       lane_active_i,
  input  logic [`LTSSM_NUM_LANES-1:0]                       ts1_valid_i,
  input  logic [`LTSSM_NUM_LANES-1:0]                       ts2_valid_i,
  input  logic [`LTSSM_NUM_LANES-1:0][7:0]                  rx_link_num_i,
  input  logic [`LTSSM_NUM_LANES-1:0][7:0]                  rx_lane_num_i,
  input  ltssm_rcvr_pkg::ts_symbol6_u [`LTSSM_NUM_LANES-1:0] symbol6_i,
  output logic [31:0]                                       tdata_o,
  output logic                                              tvalid_o,
  output logic                                              tlast_o,
  input  logic                                              tready_i,
  output logic                                              success_o,
  output logic                                              error_o,
  output logic                                              goto_cfg_o,
  output logic                                              goto_detect_o
);

  import ltssm_rcvr_pkg::*;

  // transmitter link
  logic     send;
  os_kind_e kind;
  logic     frame_end;

  ltssm_rcvr_lane_if lane_if ();

  ltssm_rcvr_lane_cnt u_lane_cnt (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .lane_if         (lane_if.lane),
    .ts1_valid_i     (ts1_valid_i),
    .ts2_valid_i     (ts2_valid_i),
    .rx_link_num_i   (rx_link_num_i),
    .rx_lane_num_i   (rx_lane_num_i),
    .symbol6_i       (symbol6_i),
    .link_num_i      (link_num_i),
    .max_rate_gen3_i (max_rate_gen3_i)
  );

  ltssm_rcvr_fsm #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) u_fsm (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .en_i          (en_i),
    .lane_active_i (lane_active_i),
    .lane_if       (lane_if.fsm),
    .send_o        (send),
    .kind_o        (kind),
    .frame_end_i   (frame_end),
    .success_o     (success_o),
    .error_o       (error_o),
    .goto_cfg_o    (goto_cfg_o),
    .goto_detect_o (goto_detect_o)
  );

  ltssm_rcvr_os_tx u_os_tx (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .send_i          (send),
    .kind_i          (kind),
    .link_num_i      (link_num_i),
    .max_rate_gen3_i (max_rate_gen3_i),
    .frame_end_o     (frame_end),
    .tdata_o         (tdata_o),
    .tvalid_o        (tvalid_o),
    .tlast_o         (tlast_o),
    .tready_i        (tready_i)
  );

endmodule

`default_nettype wire
